//--- cache_subsys.f
+incdir+rtl
rtl/cache_pkg.sv
rtl/cache_ram.sv
rtl/cache_ctrl.sv
rtl/cache_resp.sv
rtl/cache_top.sv
tests/cache_clk_gen.sv
tests/cache_mem_model.sv
tests/cache_chk.sv
tests/cache_tb.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = cache_tb
FILELIST  = cache_subsys.f
LOG       = sim.log
SIM       = obj_dir/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: compile
	./$(SIM) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Test FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "Test OK" $(LOG) || (echo "simulation ended without passing"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

//--- tests/cache_tb.sv
`default_nettype none

`include "cache_defines.svh"

module cache_tb;
	import cache_pkg::*;

	localparam int TIMEOUT = 500;  // cycles per wait.

	wire         clk;
	logic        rst_n;
	logic        c_access;
	word_addr_t  c_addr;
	word_t       c_wr_val;
	logic        c_wr_en;
	bytesel_t    c_bytesel;
	logic        cacheable_addr;
	logic        c_inval;
	logic        c_flush;
	line_index_t c_index;
	wire word_t  c_data;
	wire         c_ack;
	wire         c_error;
	wire         cacheop_complete;
	wire         cache_ready;
	wire         m_access;
	wire word_addr_t m_addr;
	wire word_t  m_wr_val;
	wire         m_wr_en;
	wire bytesel_t m_bytesel;
	wire word_t  m_data;
	wire         m_ack;
	wire         m_error;

	logic [31:0] lfsr;
	word_t       shadow_mem [word_addr_t];   // expected memory contents.
	word_t       dirty_words [word_addr_t];  // expected dirty cache data.

	cache_clk_gen u_clk (.clk);
	cache_top u_cache_top (.*);
	cache_mem_model u_mem (.*);

	// ------------------------------------------------------------
	// helpers
	// ------------------------------------------------------------
	function automatic word_t random_word();
		word_t r;
		r = '0;
		for (int i = 0; i < 32; i++) begin
			r = {r[30:0], lfsr[0]};
			lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h80200003 : 32'h0);
		end
		return r;
	endfunction

	function automatic word_t expected_mem(word_addr_t a);
		if (shadow_mem.exists(a))
			return shadow_mem[a];
		return (32'(a) * 32'h2545f491) ^ 32'hc3a50f1e;
	endfunction

	function automatic word_t merge_bytes(word_t old_val, word_t new_val, bytesel_t sel);
		word_t w;
		w = old_val;
		for (int b = 0; b < 4; b++)
			if (sel[b])
				w[8*b +: 8] = new_val[8*b +: 8];
		return w;
	endfunction

	function automatic word_addr_t make_addr(logic [`CACHE_TAG_BITS-1:0] tag,
		line_index_t idx, logic [`CACHE_OFFSET_BITS-1:0] off);
		return {tag, idx, off};
	endfunction

	task automatic report_failure(string msg);
		$display("%s", msg);
		$display("Test FAILED");
		$fatal(1);
	endtask

	task automatic check_word(string name, word_t exp, word_t act);
		if (exp !== act)
			report_failure($sformatf("FAIL %s expected %h actual %h", name, exp, act));
	endtask

	task automatic check_flag(string name, logic exp, logic act);
		if (exp !== act)
			report_failure($sformatf("FAIL %s expected %b actual %b", name, exp, act));
	endtask

	task automatic check_reset_outputs();
		check_flag("reset c_ack", 1'b0, c_ack);
		check_flag("reset c_error", 1'b0, c_error);
		check_flag("reset cacheop_complete", 1'b0, cacheop_complete);
		check_flag("reset m_access", 1'b0, m_access);
		check_flag("reset cache_ready", 1'b0, cache_ready);
	endtask

	task automatic wait_ready(output int cycles);
		cycles = 0;
		while (!cache_ready) begin
			@(negedge clk);
			cycles++;
			if (cycles > TIMEOUT)
				report_failure("cache_ready never rose after reset");
		end
	endtask

	// lat counts the cycles from c_access to c_ack.
	task automatic cpu_access(input word_addr_t addr, input logic wr, input word_t wval,
		input bytesel_t sel, input logic cacheable, output word_t rdata,
		output logic err, output int lat);
		@(posedge clk);
		c_access       <= 1'b1;
		c_addr         <= addr;
		c_wr_en        <= wr;
		c_wr_val       <= wval;
		c_bytesel      <= sel;
		cacheable_addr <= cacheable;
		@(posedge clk);
		c_access <= 1'b0;
		lat = 0;
		do begin
			@(negedge clk);
			lat++;
			if (lat > TIMEOUT)
				report_failure($sformatf("no c_ack for access to %h", addr));
		end while (!c_ack);
		rdata = c_data;
		err   = c_error;
	endtask

	task automatic line_op(input logic flush, input line_index_t idx, output int lat);
		@(posedge clk);
		c_flush <= flush;
		c_inval <= !flush;
		c_index <= idx;
		@(posedge clk);
		c_flush <= 1'b0;
		c_inval <= 1'b0;
		lat = 0;
		do begin
			@(negedge clk);
			lat++;
			if (lat > TIMEOUT)
				report_failure($sformatf("no cacheop_complete for line %0d", idx));
		end while (!cacheop_complete);
	endtask

	task automatic check_latency(string name, int exp, int act);
		if (exp != act)
			report_failure($sformatf("FAIL %s expected %0d cycles actual %0d", name, exp, act));
	endtask

	// ------------------------------------------------------------
	// directed tests
	// ------------------------------------------------------------
	word_addr_t addr_a;
	word_addr_t addr_b;
	word_addr_t addr_c;
	word_addr_t addr_d;

	task automatic read_miss_hit();
		word_t d;
		logic  e;
		int    lat;
		cpu_access(addr_a, 1'b0, '0, '1, 1'b1, d, e, lat);
		check_word("read_miss_hit miss", expected_mem(addr_a), d);
		check_flag("read_miss_hit miss error", 1'b0, e);
		cpu_access(addr_a, 1'b0, '0, '1, 1'b1, d, e, lat);
		check_word("read_miss_hit hit", expected_mem(addr_a), d);
		check_latency("read_miss_hit latency", 2, lat);
	endtask

	task automatic write_hit();
		word_t d;
		word_t v;
		logic  e;
		int    lat;
		v = random_word();
		cpu_access(addr_a, 1'b1, v, 4'b0101, 1'b1, d, e, lat);
		check_latency("write_hit latency", 2, lat);
		dirty_words[addr_a] = merge_bytes(expected_mem(addr_a), v, 4'b0101);
		cpu_access(addr_a, 1'b0, '0, '1, 1'b1, d, e, lat);
		check_word("write_hit merged", dirty_words[addr_a], d);
		cpu_access(addr_a, 1'b0, '0, '1, 1'b0, d, e, lat);  // memory untouched.
		check_word("write_hit memory", expected_mem(addr_a), d);
	endtask

	task automatic dirty_eviction();
		word_t d;
		logic  e;
		int    lat;
		cpu_access(addr_b, 1'b0, '0, '1, 1'b1, d, e, lat);
		check_word("dirty_eviction new line", expected_mem(addr_b), d);
		shadow_mem[addr_a] = dirty_words[addr_a];
		dirty_words.delete(addr_a);
		cpu_access(addr_a, 1'b0, '0, '1, 1'b0, d, e, lat);
		check_word("dirty_eviction memory", expected_mem(addr_a), d);
	endtask

	task automatic write_miss();
		word_t d;
		word_t v;
		logic  e;
		int    lat;
		v = random_word();
		cpu_access(addr_c, 1'b1, v, 4'b1100, 1'b1, d, e, lat);
		check_flag("write_miss error", 1'b0, e);
		shadow_mem[addr_c] = merge_bytes(expected_mem(addr_c), v, 4'b1100);
		cpu_access(addr_c, 1'b0, '0, '1, 1'b0, d, e, lat);  // memory took the write.
		check_word("write_miss memory", expected_mem(addr_c), d);
		cpu_access(addr_c, 1'b0, '0, '1, 1'b1, d, e, lat);
		check_word("write_miss read back", expected_mem(addr_c), d);
		if (lat <= 2)
			report_failure("read after a write miss hit the cache, so the write allocated");
		cpu_access(addr_d, 1'b0, '0, '1, 1'b0, d, e, lat);
		check_word("write_miss uncached read", expected_mem(addr_d), d);
		cpu_access(addr_c, 1'b0, '0, '1, 1'b1, d, e, lat);
		check_word("write_miss line kept", expected_mem(addr_c), d);
		check_latency("write_miss line kept latency", 2, lat);
	endtask

	task automatic inval_flush();
		word_t d;
		word_t v;
		logic  e;
		int    lat;
		v = random_word();
		cpu_access(addr_c, 1'b1, v, '1, 1'b1, d, e, lat);  // dirty line for the invalidate.
		line_op(1'b0, addr_c[`CACHE_OFFSET_BITS +: `CACHE_INDEX_BITS], lat);
		check_latency("inval_flush invalidate latency", 1, lat);
		cpu_access(addr_c, 1'b0, '0, '1, 1'b1, d, e, lat);
		check_word("inval_flush lost data", expected_mem(addr_c), d);
		v = random_word();
		cpu_access(addr_b, 1'b1, v, '1, 1'b1, d, e, lat);
		check_latency("inval_flush write hit latency", 2, lat);
		line_op(1'b1, addr_b[`CACHE_OFFSET_BITS +: `CACHE_INDEX_BITS], lat);
		shadow_mem[addr_b] = v;
		cpu_access(addr_b, 1'b0, '0, '1, 1'b0, d, e, lat);
		check_word("inval_flush memory", expected_mem(addr_b), d);
		cpu_access(addr_b, 1'b0, '0, '1, 1'b1, d, e, lat);
		check_word("inval_flush line kept", v, d);
		check_latency("inval_flush line kept latency", 2, lat);
	endtask

	task automatic memory_error();
		word_addr_t bad;
		word_t      d;
		logic       e;
		int         lat;
		bad = make_addr({4'hf, 19'h01234}, 5'd20, 2'd0);
		cpu_access(bad, 1'b0, '0, '1, 1'b1, d, e, lat);
		check_flag("memory_error cached read", 1'b1, e);
		cpu_access(bad, 1'b1, random_word(), '1, 1'b0, d, e, lat);
		check_flag("memory_error uncached write", 1'b1, e);
	endtask

	initial begin
		int sweep_cycles;
		lfsr           = 32'h43e450fa;
		rst_n          = 1'b0;
		c_access       = 1'b0;
		c_addr         = '0;
		c_wr_val       = '0;
		c_wr_en        = 1'b0;
		c_bytesel      = '0;
		cacheable_addr = 1'b0;
		c_inval        = 1'b0;
		c_flush        = 1'b0;
		c_index        = '0;
		addr_a = make_addr(23'h000101, 5'd5, 2'd1);
		addr_b = make_addr(23'h000202, 5'd5, 2'd2);
		addr_c = make_addr(23'h000303, 5'd9, 2'd0);
		addr_d = make_addr(23'h000404, 5'd9, 2'd0);
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		check_reset_outputs();
		wait_ready(sweep_cycles);
		check_latency("reset sweep", `CACHE_LINES, sweep_cycles);
		read_miss_hit();
		write_hit();
		dirty_eviction();
		write_miss();
		inval_flush();
		memory_error();
		$display("Test OK");
		$finish;
	end

endmodule

`default_nettype wire

//--- tests/cache_chk.sv
`default_nettype none

module cache_chk (
	input  wire                          clk,
	input  wire                          rst_n,
	input  wire                          c_ack,
	input  wire                          c_error,
	input  wire                          m_access,
	input  wire                          m_ack,
	input  wire  cache_pkg::word_addr_t  m_addr,
	input  wire  cache_pkg::word_t       m_wr_val,
	input  wire                          m_wr_en,
	input  wire  cache_pkg::bytesel_t    m_bytesel
);

	// memory request held until acknowledged.
	m_hold: assert property (@(posedge clk) disable iff (!rst_n)
		m_access && !m_ack |=> m_access && $stable(m_addr) && $stable(m_wr_val) &&
			$stable(m_wr_en) && $stable(m_bytesel))
		else $error("memory request changed before m_ack");

	c_ack_pulse: assert property (@(posedge clk) disable iff (!rst_n) c_ack |=> !c_ack)
		else $error("c_ack held longer than one cycle");

	c_error_ack: assert property (@(posedge clk) disable iff (!rst_n) c_error |-> c_ack)
		else $error("c_error without c_ack");

endmodule

bind cache_top cache_chk u_chk (
	.clk      (clk),
	.rst_n    (rst_n),
	.c_ack    (c_ack),
	.c_error  (c_error),
	.m_access (m_access),
	.m_ack    (m_ack),
	.m_addr   (m_addr),
	.m_wr_val (m_wr_val),
	.m_wr_en  (m_wr_en),
	.m_bytesel(m_bytesel)
);

`default_nettype wire

//--- tests/cache_mem_model.sv
`default_nettype none

module cache_mem_model (
	input  wire                          clk,
	input  wire                          rst_n,
	input  wire                          m_access,
	input  wire  cache_pkg::word_addr_t  m_addr,
	input  wire  cache_pkg::word_t       m_wr_val,
	input  wire                          m_wr_en,
	input  wire  cache_pkg::bytesel_t    m_bytesel,
	output cache_pkg::word_t             m_data,
	output logic                         m_ack,
	output logic                         m_error
);
	import cache_pkg::*;

	word_t       mem [word_addr_t];
	logic [31:0] lfsr = 32'h43e450fa;
	logic        busy;
	int          wait_cnt;

	function automatic int random_bits(int n);
		int r;
		r = 0;
		for (int i = 0; i < n; i++) begin
			r = (r << 1) | int'(lfsr[0]);
			lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h80200003 : 32'h0);
		end
		return r;
	endfunction

	function automatic word_t stored_word(word_addr_t a);
		if (mem.exists(a))
			return mem[a];
		return (32'(a) * 32'h2545f491) ^ 32'hc3a50f1e;  // default fill.
	endfunction

	// ------------------------------------------------------------
	// one word transfer per request, random wait of 0 to 3 cycles
	// ------------------------------------------------------------
	always @(posedge clk) begin
		word_t w;
		if (!rst_n) begin
			m_ack   <= 1'b0;
			m_error <= 1'b0;
			m_data  <= '0;
			busy    <= 1'b0;
		end else begin
			m_ack   <= 1'b0;
			m_error <= 1'b0;
			if (m_access && !m_ack) begin
				if (!busy) begin
					busy     <= 1'b1;
					wait_cnt <= random_bits(2);
				end else if (wait_cnt != 0) begin
					wait_cnt <= wait_cnt - 1;
				end else begin
					busy  <= 1'b0;
					m_ack <= 1'b1;
					if (m_addr[29:26] == 4'hf) begin  // error region.
						m_error <= 1'b1;
						m_data  <= '0;
					end else if (m_wr_en) begin
						w = stored_word(m_addr);
						for (int b = 0; b < 4; b++)
							if (m_bytesel[b])
								w[8*b +: 8] = m_wr_val[8*b +: 8];
						mem[m_addr] = w;
						m_data <= '0;
					end else begin
						m_data <= stored_word(m_addr);
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- tests/cache_clk_gen.sv
`default_nettype none

module cache_clk_gen (
	output logic clk
);

	initial clk = 1'b0;

	always #20 clk = ~clk;  // 40 unit period.

endmodule

`default_nettype wire

//--- rtl/cache_top.sv
`default_nettype none

`include "cache_defines.svh"

module cache_top (
	input  wire                           clk,
	input  wire                           rst_n,
	// cpu side
	input  wire                           c_access,
	input  wire  cache_pkg::word_addr_t   c_addr,
	input  wire  cache_pkg::word_t        c_wr_val,
	input  wire                           c_wr_en,
	input  wire  cache_pkg::bytesel_t     c_bytesel,
	input  wire                           cacheable_addr,
	output wire  cache_pkg::word_t        c_data,
	output wire                           c_ack,
	output wire                           c_error,
	input  wire                           c_inval,
	input  wire                           c_flush,
	input  wire  cache_pkg::line_index_t  c_index,
	output wire                           cacheop_complete,
	output wire                           cache_ready,
	// memory side
	output wire                           m_access,
	output wire  cache_pkg::word_addr_t   m_addr,
	output wire  cache_pkg::word_t        m_wr_val,
	output wire                           m_wr_en,
	output wire  cache_pkg::bytesel_t     m_bytesel,
	input  wire  cache_pkg::word_t        m_data,
	input  wire                           m_ack,
	input  wire                           m_error
);
	import cache_pkg::*;

	logic [3:0]                       lane_wr_en;
	logic [`CACHE_LANE_ADDR_BITS-1:0] lane_wr_addr;
	logic [`CACHE_LANE_ADDR_BITS-1:0] lane_rd_addr;
	byte_t [3:0]                      lane_wr_data;
	wire  byte_t [3:0]                lane_rd_data;  // one byte per lane ram.
	logic                             sel_bypass;
	logic                             bypass_load;

	cache_ctrl u_ctrl (
		.clk, .rst_n,
		.c_access, .c_addr, .c_wr_val, .c_wr_en, .c_bytesel, .cacheable_addr,
		.c_inval, .c_flush, .c_index,
		.c_ack, .c_error, .cacheop_complete, .cache_ready,
		.m_access, .m_addr, .m_wr_val, .m_wr_en, .m_bytesel,
		.m_data, .m_ack, .m_error,
		.lane_wr_en, .lane_wr_addr, .lane_rd_addr, .lane_wr_data, .lane_rd_data,
		.sel_bypass, .bypass_load
	);

	// ------------------------------------------------------------
	// byte lane data rams
	// ------------------------------------------------------------
	for (genvar i = 0; i < 4; i++) begin : g_lane
		cache_ram #(
			.entry_t(byte_t),
			.depth  (`CACHE_LINES * `CACHE_LINE_WORDS)
		) u_lane (
			.clk    (clk),
			.wr_en  (lane_wr_en[i]),
			.wr_addr(lane_wr_addr),
			.rd_addr(lane_rd_addr),
			.wr_data(lane_wr_data[i]),
			.rd_data(lane_rd_data[i])
		);
	end

	cache_resp u_resp (
		.clk, .rst_n,
		.lane_rd_data, .m_data,
		.bypass_load, .sel_bypass,
		.c_data
	);

endmodule

`default_nettype wire

//--- rtl/cache_resp.sv
`default_nettype none

module cache_resp (
	input  wire                           clk,
	input  wire                           rst_n,
	input  wire  cache_pkg::byte_t [3:0]  lane_rd_data,
	input  wire  cache_pkg::word_t        m_data,
	input  wire                           bypass_load,
	input  wire                           sel_bypass,
	output cache_pkg::word_t              c_data
);
	import cache_pkg::*;

	word_t bypass_word;  // last uncached read.
	word_t lane_word;

	// ------------------------------------------------------------
	// bypass holding register
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n)
			bypass_word <= '0;
		else if (bypass_load)
			bypass_word <= m_data;
	end

	// ------------------------------------------------------------
	// lane assembly, lane 0 is the low byte
	// ------------------------------------------------------------
	always_comb begin
		for (int i = 0; i < 4; i++)
			lane_word[8*i +: 8] = lane_rd_data[i];
	end

	// cache word unless the access went round the cache.
	assign c_data = sel_bypass ? bypass_word : lane_word;

endmodule

`default_nettype wire

//--- rtl/cache_ctrl.sv
`default_nettype none

`include "cache_defines.svh"

module cache_ctrl (
	input  wire                                clk,
	input  wire                                rst_n,
	// cpu side
	input  wire                                c_access,
	input  wire  cache_pkg::word_addr_t        c_addr,
	input  wire  cache_pkg::word_t             c_wr_val,
	input  wire                                c_wr_en,
	input  wire  cache_pkg::bytesel_t          c_bytesel,
	input  wire                                cacheable_addr,
	input  wire                                c_inval,
	input  wire                                c_flush,
	input  wire  cache_pkg::line_index_t       c_index,
	output logic                               c_ack,
	output logic                               c_error,
	output logic                               cacheop_complete,
	output logic                               cache_ready,
	// memory side
	output logic                               m_access,
	output cache_pkg::word_addr_t              m_addr,
	output cache_pkg::word_t                   m_wr_val,
	output logic                               m_wr_en,
	output cache_pkg::bytesel_t                m_bytesel,
	input  wire  cache_pkg::word_t             m_data,
	input  wire                                m_ack,
	input  wire                                m_error,
	// byte lanes and response unit
	output logic [3:0]                         lane_wr_en,
	output logic [`CACHE_LANE_ADDR_BITS-1:0]   lane_wr_addr,
	output logic [`CACHE_LANE_ADDR_BITS-1:0]   lane_rd_addr,
	output cache_pkg::byte_t [3:0]             lane_wr_data,
	input  wire  cache_pkg::byte_t [3:0]       lane_rd_data,
	output logic                               sel_bypass,
	output logic                               bypass_load
);
	import cache_pkg::*;

	localparam int INDEX_LSB = `CACHE_OFFSET_BITS;
	localparam int TAG_LSB   = `CACHE_OFFSET_BITS + `CACHE_INDEX_BITS;

	typedef logic [`CACHE_OFFSET_BITS-1:0] offset_t;
	typedef logic [`CACHE_TAG_BITS-1:0]    tag_t;

	localparam offset_t FIRST_WORD = '0;

	typedef enum logic [2:0] {
		ST_SWEEP,
		ST_IDLE,
		ST_COMPARE,
		ST_EVICT,
		ST_FILL,
		ST_WRITE_MISS,
		ST_BYPASS,
		ST_FLUSH
	} state_t;

	state_t      state;
	state_t      next_state;
	line_index_t sweep_cnt;
	offset_t     word_cnt;  // line word in flight.

	line_index_t req_index;
	offset_t     req_offset;
	tag_t        req_tag;
	logic        req_wr_en;
	word_t       req_wr_val;
	bytesel_t    req_bytesel;

	logic        state_wr_en;
	line_index_t state_wr_addr;
	line_index_t state_rd_addr;
	line_state_t state_wr_data;
	line_state_t line_q;      // state of the addressed line.

	logic        start_access;
	logic        start_flush;
	logic        do_inval;
	logic        hit;
	logic        victim_dirty;
	logic        line_done;
	word_t       lane_word;

	assign start_access = state == ST_IDLE && c_access;
	assign start_flush  = state == ST_IDLE && !c_access && c_flush;
	assign do_inval     = state == ST_IDLE && !c_access && !c_flush && c_inval;
	assign hit          = line_q.valid && line_q.tag == req_tag;
	assign victim_dirty = line_q.valid && line_q.dirty;
	assign line_done    = m_ack && word_cnt == '1;
	assign lane_word    = lane_rd_data;
	assign bypass_load  = state == ST_BYPASS && m_ack;

	// ------------------------------------------------------------
	// tag and state ram
	// ------------------------------------------------------------
	assign state_rd_addr = state != ST_IDLE ? req_index :
		c_access ? c_addr[INDEX_LSB +: `CACHE_INDEX_BITS] : c_index;

	cache_ram #(
		.entry_t(line_state_t),
		.depth  (`CACHE_LINES)
	) u_state_ram (
		.clk    (clk),
		.wr_en  (state_wr_en),
		.wr_addr(state_wr_addr),
		.rd_addr(state_rd_addr),
		.wr_data(state_wr_data),
		.rd_data(line_q)
	);

	always_comb begin
		state_wr_en   = 1'b0;
		state_wr_addr = req_index;
		state_wr_data = '0;                          // invalid, clean.
		case (state)
		ST_SWEEP: begin
			state_wr_en   = 1'b1;
			state_wr_addr = sweep_cnt;
		end
		ST_IDLE: begin
			state_wr_en   = do_inval;
			state_wr_addr = c_index;
		end
		ST_COMPARE: begin
			state_wr_en   = hit && req_wr_en;            // write hit dirties the line.
			state_wr_data = '{valid: 1'b1, dirty: 1'b1, tag: req_tag};
		end
		ST_FILL: begin
			state_wr_en   = m_ack && (m_error || line_done);
			state_wr_data = '{valid: !m_error, dirty: 1'b0, tag: req_tag};
		end
		ST_FLUSH: begin
			state_wr_en   = line_done && !m_error;     // written back, now clean.
			state_wr_data = '{valid: 1'b1, dirty: 1'b0, tag: line_q.tag};
		end
		default: ;
		endcase
	end

	// ------------------------------------------------------------
	// byte lane write and read side
	// ------------------------------------------------------------
	always_comb begin
		lane_wr_en   = '0;
		lane_wr_addr = {req_index, req_offset};
		lane_wr_data = req_wr_val;
		lane_rd_addr = {req_index, req_offset};
		case (state)
		ST_IDLE:
			lane_rd_addr = c_access ? c_addr[0 +: `CACHE_LANE_ADDR_BITS] :
				{c_index, FIRST_WORD};
		ST_COMPARE: begin
			if (hit && req_wr_en)
				lane_wr_en = req_bytesel;              // merge written bytes.
			if (!hit)
				lane_rd_addr = {req_index, FIRST_WORD}; // victim word 0 for an evict.
		end
		ST_FILL: begin
			lane_wr_en   = {4{m_ack && !m_error}};
			lane_wr_addr = {req_index, word_cnt};
			lane_wr_data = m_data;
		end
		ST_EVICT, ST_FLUSH:
			lane_rd_addr = {req_index, offset_t'(word_cnt + offset_t'(m_ack))};  // read ahead.
		default: ;
		endcase
	end

	// ------------------------------------------------------------
	// memory bus driver
	// ------------------------------------------------------------
	always_comb begin
		m_access  = 1'b0;
		m_addr    = {req_tag, req_index, req_offset};
		m_wr_val  = req_wr_val;
		m_wr_en   = 1'b0;
		m_bytesel = req_bytesel;
		case (state)
		ST_EVICT, ST_FLUSH: begin
			m_access  = state == ST_EVICT || victim_dirty;
			m_addr    = {line_q.tag, req_index, word_cnt};
			m_wr_val  = lane_word;
			m_wr_en   = 1'b1;
			m_bytesel = '1;
		end
		ST_FILL: begin
			m_access  = 1'b1;
			m_addr    = {req_tag, req_index, word_cnt};
			m_bytesel = '1;
		end
		ST_WRITE_MISS, ST_BYPASS: begin
			m_access  = 1'b1;
			m_wr_en   = req_wr_en;
		end
		default: ;
		endcase
	end

	// ------------------------------------------------------------
	// fsm
	// ------------------------------------------------------------
	always_comb begin
		next_state = state;
		case (state)
		ST_SWEEP:
			if (sweep_cnt == '1)
				next_state = ST_IDLE;
		ST_IDLE:
			if (c_access)
				next_state = cacheable_addr ? ST_COMPARE : ST_BYPASS;
			else if (c_flush)
				next_state = ST_FLUSH;
		ST_COMPARE:
			if (hit)
				next_state = ST_IDLE;
			else if (req_wr_en)
				next_state = ST_WRITE_MISS;        // no allocate on writes.
			else if (victim_dirty)
				next_state = ST_EVICT;
			else
				next_state = ST_FILL;
		ST_EVICT:
			if (m_ack && m_error)
				next_state = ST_IDLE;
			else if (line_done)
				next_state = ST_FILL;
		ST_FILL, ST_FLUSH:
			if ((state == ST_FLUSH && !victim_dirty) || (m_ack && (m_error || line_done)))
				next_state = ST_IDLE;
		ST_WRITE_MISS, ST_BYPASS:
			if (m_ack)
				next_state = ST_IDLE;
		default:
			next_state = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state       <= ST_SWEEP;
			sweep_cnt   <= '0;
			cache_ready <= 1'b0;
			word_cnt    <= '0;
		end else begin
			state <= next_state;
			if (state == ST_SWEEP)
				sweep_cnt <= sweep_cnt + 1'b1;
			if (state == ST_SWEEP && sweep_cnt == '1)
				cache_ready <= 1'b1;
			if (state == ST_IDLE)
				word_cnt <= '0;
			else if (m_ack && (state == ST_EVICT || state == ST_FILL || state == ST_FLUSH))
				word_cnt <= word_cnt + 1'b1;  // wraps to 0 between evict and fill.
		end
	end

	// cpu strobes, one cycle each
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			c_ack            <= 1'b0;
			c_error          <= 1'b0;
			cacheop_complete <= 1'b0;
			sel_bypass       <= 1'b0;
		end else begin
			c_ack            <= 1'b0;
			c_error          <= 1'b0;
			cacheop_complete <= 1'b0;
			sel_bypass       <= 1'b0;
			case (state)
			ST_IDLE:
				cacheop_complete <= do_inval;
			ST_COMPARE:
				c_ack <= hit;
			ST_EVICT: begin
				c_ack   <= m_ack && m_error;       // give up, victim stays dirty.
				c_error <= m_ack && m_error;
			end
			ST_FILL: begin
				c_ack   <= m_ack && (m_error || line_done);
				c_error <= m_ack && m_error;
			end
			ST_WRITE_MISS, ST_BYPASS: begin
				c_ack      <= m_ack;
				c_error    <= m_ack && m_error;
				sel_bypass <= state == ST_BYPASS && m_ack;
			end
			ST_FLUSH:
				cacheop_complete <= !victim_dirty || (m_ack && (m_error || line_done));
			default: ;
			endcase
		end
	end

	// request latch
	always_ff @(posedge clk) begin
		if (start_access) begin
			req_index   <= c_addr[INDEX_LSB +: `CACHE_INDEX_BITS];
			req_offset  <= c_addr[0 +: `CACHE_OFFSET_BITS];
			req_tag     <= c_addr[TAG_LSB +: `CACHE_TAG_BITS];
			req_wr_en   <= c_wr_en;
			req_wr_val  <= c_wr_val;
			req_bytesel <= c_bytesel;
		end else if (start_flush) begin
			req_index   <= c_index;
		end
	end

endmodule

`default_nettype wire

//--- rtl/cache_ram.sv
`default_nettype none

module cache_ram #(
	parameter type entry_t = logic [7:0],
	parameter int  depth   = 128
) (
	input  wire                       clk,
	input  wire                       wr_en,
	input  wire  [$clog2(depth)-1:0]  wr_addr,
	input  wire  [$clog2(depth)-1:0]  rd_addr,
	input  wire  entry_t              wr_data,
	output entry_t                    rd_data
);

	entry_t mem [depth];

	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
	end

	// registered read, new data wins on a collision.
	always_ff @(posedge clk) begin
		if (wr_en && wr_addr == rd_addr)
			rd_data <= wr_data;
		else
			rd_data <= mem[rd_addr];
	end

endmodule

`default_nettype wire

//--- rtl/cache_pkg.sv
`default_nettype none

`include "cache_defines.svh"

package cache_pkg;

	// ------------------------------------------------------------
	// bus types
	// ------------------------------------------------------------
	typedef logic [`CACHE_WORD_ADDR_BITS-1:0] word_addr_t;  // cpu and memory address.
	typedef logic [31:0]                      word_t;
	typedef logic [7:0]                       byte_t;       // one lane entry.
	typedef logic [3:0]                       bytesel_t;    // bit n enables byte n.

	// ------------------------------------------------------------
	// line bookkeeping
	// ------------------------------------------------------------
	typedef logic [`CACHE_INDEX_BITS-1:0] line_index_t;

	// one entry of the state ram, 25 bits.
	typedef struct packed {
		logic                       valid;
		logic                       dirty;  // line differs from memory.
		logic [`CACHE_TAG_BITS-1:0] tag;
	} line_state_t;

endpackage

`default_nettype wire

//--- rtl/cache_defines.svh
`ifndef CACHE_DEFINES_SVH
`define CACHE_DEFINES_SVH

// ------------------------------------------------------------
// cache geometry
// ------------------------------------------------------------
`define CACHE_SIZE           512   // total data bytes.
`define CACHE_LINE_SIZE      16    // bytes per line.
`define CACHE_LINE_WORDS     (`CACHE_LINE_SIZE / 4)
`define CACHE_LINES          (`CACHE_SIZE / `CACHE_LINE_SIZE)

// ------------------------------------------------------------
// word address split: tag | index | offset
// ------------------------------------------------------------
`define CACHE_WORD_ADDR_BITS 30
`define CACHE_OFFSET_BITS    2     // word within a line.
`define CACHE_INDEX_BITS     5     // line select.
`define CACHE_TAG_BITS       (`CACHE_WORD_ADDR_BITS - `CACHE_INDEX_BITS - `CACHE_OFFSET_BITS)

// byte lane rams hold one byte of every word in the cache
`define CACHE_LANE_ADDR_BITS (`CACHE_INDEX_BITS + `CACHE_OFFSET_BITS)

`endif
